// ==== sources.f ====
hdl/div_types_pkg.sv
hdl/div_flow_pkg.sv
hdl/credit_fifo.sv
hdl/div8_core.sv
hdl/result_credit_gate.sv
hdl/div_unit_top.sv
test/div_unit_assertions.sv
test/div_unit_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

dependencies: {}

sources:
  # RTL, packages first
  - files:
      - hdl/div_types_pkg.sv
      - hdl/div_flow_pkg.sv
      - hdl/credit_fifo.sv
      - hdl/div8_core.sv
      - hdl/result_credit_gate.sv
      - hdl/div_unit_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/div_unit_assertions.sv
      - test/div_unit_tb.sv

# top levels
#   RTL: div_unit_top
#   simulation: div_unit_tb

// ==== test/div_unit_tb.sv ====
`timescale 1ns/1ps

module div_unit_tb
    import div_types_pkg::*, div_flow_pkg::*;
();

    localparam int n_directed = 7;
    localparam int n_zero     = 3;     // divide by zero cases
    localparam int n_random   = 300;
    localparam int n_hold     = 24;    // sent while the consumer sits on its credits
    localparam int total_cmds = n_directed + n_zero + n_random + n_hold;
    localparam int rst_cycles = 16;

    logic              sys_clk;
    logic              sys_rst_l;
    logic              cmd_valid;
    logic [data_w-1:0] cmd_dividend;
    logic [data_w-1:0] cmd_divisor;
    logic [tag_w-1:0]  cmd_tag;
    logic              cmd_credit;
    logic              res_valid;
    logic [data_w-1:0] res_quotient;
    logic [data_w-1:0] res_remainder;
    logic [tag_w-1:0]  res_tag;
    logic              res_credit;

    div_res_t         exp_q[$];     // expected results in command order
    int               due_q[$];     // cycle numbers of pending consumer credits
    int               cmd_cred;     // producer credits in hand
    int               cons_cred;    // consumer slots the unit may still fill
    int               sent;
    int               received;
    int               cycle;
    int               last_due;
    logic [tag_w-1:0] tag_next;
    logic             long_hold;    // consumer slow to free slots

    div_unit_top i_div_unit_top (
        .sys_clk       (sys_clk),
        .sys_rst_l     (sys_rst_l),
        .cmd_valid     (cmd_valid),
        .cmd_dividend  (cmd_dividend),
        .cmd_divisor   (cmd_divisor),
        .cmd_tag       (cmd_tag),
        .cmd_credit    (cmd_credit),
        .res_valid     (res_valid),
        .res_quotient  (res_quotient),
        .res_remainder (res_remainder),
        .res_tag       (res_tag),
        .res_credit    (res_credit)
    );

    bind div_unit_top div_unit_assertions i_div_unit_assertions (
        .sys_clk    (sys_clk),
        .sys_rst_l  (sys_rst_l),
        .cmd_valid  (cmd_valid),
        .cmd_full   (cmd_full),
        .cmd_credit (cmd_credit),
        .res_valid  (res_valid),
        .gate_cnt   (i_result_credit_gate.credit_cnt)
    );

    always #10 sys_clk = ~sys_clk;   // 20 ns period

    // integer division, zero divisor gives all ones and the dividend back
    function automatic div_res_t ref_divide(input logic [data_w-1:0] a,
                                            input logic [data_w-1:0] b,
                                            input logic [tag_w-1:0] t);
        div_res_t r;
        if (b == 0) begin
            r.quotient  = 8'hff;
            r.remainder = a;
        end else begin
            r.quotient  = a / b;
            r.remainder = a % b;
        end
        r.tag = t;
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    // called one ns after a rising edge, returns at the same point
    task automatic send_cmd(input logic [data_w-1:0] a, input logic [data_w-1:0] b);
        while (cmd_cred == 0) begin
            cmd_valid = 1'b0;   // out of credits, stall
            @(posedge sys_clk);
            #1;
        end
        cmd_valid    = 1'b1;
        cmd_dividend = a;
        cmd_divisor  = b;
        cmd_tag      = tag_next;
        exp_q.push_back(ref_divide(a, b, tag_next));
        cmd_cred--;
        sent++;
        tag_next++;
        @(posedge sys_clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // producer credit return
    always @(negedge sys_clk) begin
        if (sys_rst_l && cmd_credit) begin
            if (cmd_cred == cmd_depth) begin
                fail_run("cmd_credit pulsed with no command outstanding");
            end else begin
                cmd_cred++;
            end
        end
    end

    // compare process, also schedules the consumer credit for each result
    always @(negedge sys_clk) begin
        div_res_t exp_res;
        int       delay;
        if (sys_rst_l && res_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("result arrived with no command outstanding");
            end else if (cons_cred == 0) begin
                fail_run("res_valid rose while the consumer had no free slot");
            end else begin
                exp_res = exp_q.pop_front();
                check_eq("res_quotient", res_quotient, exp_res.quotient);
                check_eq("res_remainder", res_remainder, exp_res.remainder);
                check_eq("res_tag", res_tag, exp_res.tag);   // catches reordering
                cons_cred--;
                received++;
                delay    = long_hold ? $urandom_range(20, 40) : $urandom_range(0, 6);
                last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1;
                due_q.push_back(last_due);   // one credit pulse per cycle at most
            end
        end
    end

    // consumer frees slots
    always begin
        @(posedge sys_clk);
        #1;
        res_credit = 1'b0;
        cycle++;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            res_credit = 1'b1;
            cons_cred++;
        end
    end

    // watchdog, sized from the command count
    initial begin
        #((total_cmds * (9 + 12) + rst_cycles) * 20);
        fail_run("watchdog expired, results stopped arriving");
    end

    initial begin
        void'($urandom(46909));
        sys_clk      = 1'b0;
        sys_rst_l    = 1'b0;
        cmd_valid    = 1'b0;
        cmd_dividend = '0;
        cmd_divisor  = '0;
        cmd_tag      = '0;
        res_credit   = 1'b0;
        cmd_cred     = cmd_depth;
        cons_cred    = res_credits;
        sent         = 0;
        received     = 0;
        cycle        = 0;
        last_due     = 0;
        tag_next     = '0;
        long_hold    = 1'b0;
        repeat (rst_cycles) @(posedge sys_clk);
        #1;
        sys_rst_l = 1'b1;

        // quiet outputs before any command
        repeat (5) begin
            @(negedge sys_clk);
            check_eq("cmd_credit", cmd_credit, 0);
            check_eq("res_valid", res_valid, 0);
        end
        @(posedge sys_clk);
        #1;

        send_cmd(8'd0, 8'd1);
        send_cmd(8'd255, 8'd1);
        send_cmd(8'd255, 8'd255);
        send_cmd(8'd7, 8'd200);
        send_cmd(8'd200, 8'd7);
        send_cmd(8'd100, 8'd10);
        send_cmd(8'd1, 8'd255);
        send_cmd(8'd0, 8'd0);
        send_cmd(8'd37, 8'd0);
        send_cmd(8'd255, 8'd0);

        // back to back, full credit use
        repeat (n_random) send_cmd($urandom_range(0, 255), $urandom_range(0, 255));
        wait (received == sent);

        // consumer withholds, result queue and core back up
        long_hold = 1'b1;
        repeat (n_hold) send_cmd($urandom_range(0, 255), $urandom_range(0, 255));
        wait (received == sent);
        long_hold = 1'b0;
        repeat (8) @(posedge sys_clk);

        if (cmd_cred == cmd_depth) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("ERROR: producer credits 0x%0h expected 0x%0h", cmd_cred, cmd_depth);
            $display("STATUS: FAIL");
            $fatal(1, "credit count wrong at end of run");
        end
    end

endmodule

// ==== test/div_unit_assertions.sv ====
`timescale 1ns/1ps

module div_unit_assertions
    import div_flow_pkg::*;
(
    input logic                    sys_clk,
    input logic                    sys_rst_l,
    input logic                    cmd_valid,
    input logic                    cmd_full,
    input logic                    cmd_credit,
    input logic                    res_valid,
    input logic [credit_cnt_w-1:0] gate_cnt      // consumer credit counter in the gate
);

    int write_total;    // commands taken into the queue so far
    int credit_total;   // cmd_credit pulses so far

    always_ff @(posedge sys_clk or negedge sys_rst_l) begin
        if (!sys_rst_l) begin
            write_total  <= 0;
            credit_total <= 0;
        end else begin
            write_total  <= write_total + ((cmd_valid && !cmd_full) ? 1 : 0);
            credit_total <= credit_total + (cmd_credit ? 1 : 0);
        end
    end

    cmd_no_overrun: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
        cmd_valid |-> !cmd_full) else $error("command queue written while full");

    res_valid_needs_credit: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
        res_valid |-> $past(gate_cnt) != 0) else $error("res_valid with no consumer credit");

    gate_cnt_bounded: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
        gate_cnt <= credit_cnt_w'(res_credits)) else $error("consumer credit count too high");

    cmd_credit_follows_write: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
        cmd_credit |-> credit_total < write_total) else $error("cmd_credit without a write");

endmodule

// ==== hdl/div_unit_top.sv ====
`timescale 1ns/1ps

module div_unit_top
    import div_types_pkg::*, div_flow_pkg::*;
(
    input  logic              sys_clk,
    input  logic              sys_rst_l,
    // producer side
    input  logic              cmd_valid,      // only while the producer holds a credit
    input  logic [data_w-1:0] cmd_dividend,
    input  logic [data_w-1:0] cmd_divisor,
    input  logic [tag_w-1:0]  cmd_tag,
    output logic              cmd_credit,     // one pulse per command taken by the core
    // consumer side
    output logic              res_valid,
    output logic [data_w-1:0] res_quotient,
    output logic [data_w-1:0] res_remainder,
    output logic [tag_w-1:0]  res_tag,
    input  logic              res_credit
);

    div_cmd_t cmd_wdata;
    div_cmd_t cmd_head;
    logic     cmd_empty;
    logic     cmd_full;      // never set while the producer keeps to its credits
    logic     cmd_pop;
    div_res_t res_wdata;
    div_res_t res_head;
    logic     res_push;
    logic     res_pop;
    logic     res_empty;
    logic     res_full;

    assign cmd_wdata = '{dividend: cmd_dividend, divisor: cmd_divisor, tag: cmd_tag};

    credit_fifo #(.depth(cmd_depth), .payload_t(div_cmd_t)) i_cmd_fifo (
        .sys_clk    (sys_clk),
        .sys_rst_l  (sys_rst_l),
        .push       (cmd_valid),
        .push_data  (cmd_wdata),
        .pop        (cmd_pop),
        .pop_data   (cmd_head),
        .full       (cmd_full),
        .empty      (cmd_empty),
        .pop_credit (cmd_credit)
    );

    div8_core i_div8_core (
        .sys_clk   (sys_clk),
        .sys_rst_l (sys_rst_l),
        .cmd_empty (cmd_empty),
        .cmd_head  (cmd_head),
        .cmd_pop   (cmd_pop),
        .res_full  (res_full),
        .res_push  (res_push),
        .res_data  (res_wdata)
    );

    // result side is paced by the gate counter, queue credit left open
    credit_fifo #(.depth(res_depth), .payload_t(div_res_t)) i_res_fifo (
        .sys_clk    (sys_clk),
        .sys_rst_l  (sys_rst_l),
        .push       (res_push),
        .push_data  (res_wdata),
        .pop        (res_pop),
        .pop_data   (res_head),
        .full       (res_full),
        .empty      (res_empty),
        .pop_credit ()
    );

    result_credit_gate i_result_credit_gate (
        .sys_clk       (sys_clk),
        .sys_rst_l     (sys_rst_l),
        .res_empty     (res_empty),
        .res_head      (res_head),
        .res_pop       (res_pop),
        .res_credit    (res_credit),
        .res_valid     (res_valid),
        .res_quotient  (res_quotient),
        .res_remainder (res_remainder),
        .res_tag       (res_tag)
    );

endmodule

// ==== hdl/result_credit_gate.sv ====
`timescale 1ns/1ps

module result_credit_gate
    import div_types_pkg::*, div_flow_pkg::*;
(
    input  logic              sys_clk,
    input  logic              sys_rst_l,
    input  logic              res_empty,
    input  div_res_t          res_head,
    output logic              res_pop,
    input  logic              res_credit,      // consumer freed a slot
    output logic              res_valid,
    output logic [data_w-1:0] res_quotient,
    output logic [data_w-1:0] res_remainder,
    output logic [tag_w-1:0]  res_tag
);

    logic [credit_cnt_w-1:0] credit_cnt;   // free consumer slots

    // send only with a result waiting and a slot free
    assign res_pop = !res_empty && (credit_cnt != '0);

    always_ff @(posedge sys_clk or negedge sys_rst_l) begin
        if (!sys_rst_l) begin
            credit_cnt <= credit_cnt_w'(res_credits);
        end else begin
            case ({res_pop, res_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;   // spent
                2'b01:   credit_cnt <= credit_cnt + 1'b1;   // returned
                default: credit_cnt <= credit_cnt;          // both or neither
            endcase
        end
    end

    // one cycle valid per popped entry
    always_ff @(posedge sys_clk or negedge sys_rst_l) begin
        if (!sys_rst_l) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= res_pop;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (res_pop) begin
            res_quotient  <= res_head.quotient;
            res_remainder <= res_head.remainder;
            res_tag       <= res_head.tag;
        end
    end

endmodule

// ==== hdl/div8_core.sv ====
`timescale 1ns/1ps

module div8_core
    import div_types_pkg::*;
(
    input  logic     sys_clk,
    input  logic     sys_rst_l,
    input  logic     cmd_empty,
    input  div_cmd_t cmd_head,
    output logic     cmd_pop,
    input  logic     res_full,
    output logic     res_push,
    output div_res_t res_data
);

    localparam int idx_w = $clog2(data_w);

    div_state_e            state;
    logic [data_w-1:0]     work_rem;    // running remainder, final value is the remainder
    logic [data_w-1:0]     work_dvs;    // divisor held for the whole division
    logic [data_w-1:0]     quo;
    logic [tag_w-1:0]      work_tag;
    logic [idx_w-1:0]      bit_idx;     // quotient bit of the current state
    logic                  bit_state;
    logic [2*data_w-1:0]   dvs_shift;   // divisor << bit_idx, kept 16 bits wide
    logic [data_w:0]       diff;        // 9 bit, msb is the borrow
    logic                  spill;
    logic                  take;

    // quotient bit index per state
    always_comb begin
        bit_state = 1'b1;
        case (state)
            st_bit7: bit_idx = 3'd7;
            st_bit6: bit_idx = 3'd6;
            st_bit5: bit_idx = 3'd5;
            st_bit4: bit_idx = 3'd4;
            st_bit3: bit_idx = 3'd3;
            st_bit2: bit_idx = 3'd2;
            st_bit1: bit_idx = 3'd1;
            st_bit0: bit_idx = 3'd0;
            default: begin
                bit_idx   = 3'd0;   // idle and done, no subtraction
                bit_state = 1'b0;
            end
        endcase
    end

    assign dvs_shift = {{data_w{1'b0}}, work_dvs} << bit_idx;
    assign spill     = |dvs_shift[2*data_w-1:data_w];   // shifted divisor above 255
    assign diff      = {1'b0, work_rem} - {1'b0, dvs_shift[data_w-1:0]};
    // a zero divisor always takes, which gives 0xff and the dividend
    assign take      = !diff[data_w] && !spill;

    assign cmd_pop  = (state == st_idle) && !cmd_empty;
    assign res_push = (state == st_done) && !res_full;   // hold while the queue is full
    assign res_data = '{quotient: quo, remainder: work_rem, tag: work_tag};

    always_ff @(posedge sys_clk or negedge sys_rst_l) begin
        if (!sys_rst_l) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (!cmd_empty) begin
                        state <= st_bit7;   // command popped this cycle
                    end
                end
                st_bit7: state <= st_bit6;
                st_bit6: state <= st_bit5;
                st_bit5: state <= st_bit4;
                st_bit4: state <= st_bit3;
                st_bit3: state <= st_bit2;
                st_bit2: state <= st_bit1;
                st_bit1: state <= st_bit0;
                st_bit0: state <= st_done;
                st_done: begin
                    if (!res_full) begin
                        state <= st_idle;   // pushed this cycle
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // operand load at pop, one quotient bit per bit state
    always_ff @(posedge sys_clk) begin
        if (cmd_pop) begin
            work_rem <= cmd_head.dividend;
            work_dvs <= cmd_head.divisor;
            work_tag <= cmd_head.tag;
        end else if (bit_state) begin
            quo[bit_idx] <= take;
            if (take) begin
                work_rem <= diff[data_w-1:0];   // keep the difference
            end
        end
    end

endmodule

// ==== hdl/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter int  depth     = 4,             // power of two
    parameter type payload_t = logic [7:0]
) (
    input  logic     sys_clk,
    input  logic     sys_rst_l,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,       // head, valid while not empty
    output logic     full,
    output logic     empty,
    output logic     pop_credit      // one pulse per freed slot
);

    localparam int addr_w = $clog2(depth);

    payload_t        mem [depth];
    logic [addr_w:0] wr_ptr;         // extra msb tells full from empty
    logic [addr_w:0] rd_ptr;
    logic            wr_en;
    logic            rd_en;

    // writes into a full queue and reads from an empty one are dropped
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign empty = (wr_ptr == rd_ptr);
    // same slot, wrapped a different number of times
    assign full  = (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]) &&
                   (wr_ptr[addr_w] != rd_ptr[addr_w]);

    assign pop_data = mem[rd_ptr[addr_w-1:0]];   // first word fall through

    always_ff @(posedge sys_clk or negedge sys_rst_l) begin
        if (!sys_rst_l) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_l) begin
        if (!sys_rst_l) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_ptr[addr_w-1:0]] <= push_data;
        end
    end

    // credit goes back the cycle after the slot frees
    always_ff @(posedge sys_clk or negedge sys_rst_l) begin
        if (!sys_rst_l) begin
            pop_credit <= 1'b0;
        end else begin
            pop_credit <= rd_en;
        end
    end

endmodule

// ==== hdl/div_flow_pkg.sv ====
package div_flow_pkg;

    // command side
    // producer starts with one credit per slot
    localparam int cmd_depth = 4;

    // result side
    localparam int res_depth = 4;

    // consumer slots granted after reset
    // the gate counter starts here and never goes above it
    localparam int res_credits = 2;

    // wide enough for the largest count, cmd_depth included
    localparam int credit_cnt_w = 3;

endpackage

// ==== hdl/div_types_pkg.sv ====
package div_types_pkg;

    localparam int data_w = 8;   // dividend, divisor, quotient, remainder
    localparam int tag_w  = 4;   // producer tag, returned with the result

    // command payload as written by the producer, 20 bits
    typedef struct packed {
        logic [data_w-1:0] dividend;
        logic [data_w-1:0] divisor;
        logic [tag_w-1:0]  tag;
    } div_cmd_t;

    // result payload toward the consumer, 20 bits
    typedef struct packed {
        logic [data_w-1:0] quotient;
        logic [data_w-1:0] remainder;
        logic [tag_w-1:0]  tag;
    } div_res_t;

    // divider sequence: one state per quotient bit, msb first
    typedef enum logic [3:0] {
        st_idle = 4'h0,   // waiting for a command
        st_bit7 = 4'h1,   // divisor << 7
        st_bit6 = 4'h2,
        st_bit5 = 4'h3,
        st_bit4 = 4'h4,
        st_bit3 = 4'h5,
        st_bit2 = 4'h6,
        st_bit1 = 4'h7,
        st_bit0 = 4'h8,   // divisor << 0
        st_done = 4'h9    // result held until the result queue takes it
    } div_state_e;

endpackage
